// ==== sim.f ====
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/dx_if.sv
design/xw_if.sv
design/inst_wb_slave.sv
design/decode_stage.sv
design/regfile.sv
design/execute_stage.sv
design/writeback_stage.sv
design/rv_alu_pipe_top.sv
tb/tb_top.sv

// ==== tb/alu_golden.txt ====
// we  instruction  exp_wen  exp_rd  exp_data  exp_taken  (all hex)
// Sequential execution from all registers zero, we=0 lines expect no result
1 00500093 1 01 00000005 0
1 FFD00113 1 02 FFFFFFFD 0
1 800001B7 1 03 80000000 0
1 00208233 1 04 00000002 0
1 402082B3 1 05 00000008 0
1 00109333 1 06 000000A0 0
1 001123B3 1 07 00000001 0
1 00113433 1 08 00000000 0
1 0020C4B3 1 09 FFFFFFF8 0
1 0011D533 1 0A 04000000 0
1 4011D5B3 1 0B FC000000 0
1 0030E633 1 0C 80000005 0
1 001176B3 1 0D 00000005 0
1 FFF12713 1 0E 00000001 0
1 FFF0B793 1 0F 00000001 0
1 7FF0C813 1 10 000007FA 0
1 0F00E893 1 11 000000F5 0
1 8F017913 1 12 FFFFF8F0 0
1 01F09993 1 13 80000000 0
1 00415A13 1 14 0FFFFFFF 0
1 40115A93 1 15 FFFFFFFE 0
1 00AA8B13 1 16 00000008 0
1 00708013 0 00 0000000C 0
1 00000C33 1 18 00000000 0
1 415B0CB3 1 19 0000000A 0
1 019C8BB3 1 17 00000014 0
0 DEADBEEF 0 00 00000000 0
1 02D08063 0 00 00000000 1
1 02D09063 0 00 00000000 0
1 02114063 0 00 00000000 1
1 02115063 0 00 00000000 0
1 02116063 0 00 00000000 0
1 02117063 0 00 00000000 1

// ==== tb/tb_top.sv ====
// Testbench for the RISC-V integer execute pipeline
// Wishbone master fed from a golden file, results checked at writeback
`timescale 1ns/1ns

module tb_top;

  localparam int CLK_PERIOD = 20;
  localparam int DRIVE_DLY  = 2;    // Inputs change just after the edge
  localparam int MAX_TESTS  = 64;
  localparam int COLS       = 6;    // we, inst, wen, rd, data, taken
  localparam int WAIT_LIMIT = 16;   // Cycles before a wait gives up

  logic        clk;
  logic        reset;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [31:0] wb_dat_i;
  logic        wb_ack;
  logic        result_valid;
  logic        result_wen;
  logic [4:0]  result_rd;
  logic [31:0] result_data;
  logic        result_taken;

  logic [31:0] golden [0:MAX_TESTS*COLS-1];
  int          issue_q[$];          // Test index per instruction in flight
  int          ack_q[$];            // Its ack edge
  int          cycle;               // Edges since start
  int          n_tests;
  int          tests_run;
  int          tests_failed;
  int          errors;
  bit          aborted;             // Set on a timeout
  logic [31:0] lfsr;

  rv_alu_pipe_top uut (
    .clk          (clk),
    .reset        (reset),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_dat_i     (wb_dat_i),
    .wb_ack       (wb_ack),
    .result_valid (result_valid),
    .result_wen   (result_wen),
    .result_rd    (result_rd),
    .result_data  (result_data),
    .result_taken (result_taken)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  // x^32 + x^22 + x^2 + x + 1, new bit enters at the bottom
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic check_field(input string label, input string name, input logic [31:0] got,
                             input logic [31:0] exp, inout bit ok);
    assert (got === exp) else begin
      $display("Mismatch test %s %s: got %h, expected %h", label, name, got, exp);
      errors++;
      ok = 0;
    end
  endtask

  task automatic report_test(input string label, input bit ok);
    tests_run++;
    if (!ok) tests_failed++;
    $display("Test %s: %s", label, ok ? "ok" : "FAILED");
  endtask

  // Result side, runs once per cycle
  task automatic check_result();
    int    t;
    int    ack_edge;
    bit    ok;
    string label;
    if (result_valid === 1'b1) begin
      assert (issue_q.size() != 0) else begin
        $display("result_valid seen at cycle %0d with no instruction in flight", cycle);
        errors++;
      end
      if (issue_q.size() != 0) begin
        t        = issue_q.pop_front();
        ack_edge = ack_q.pop_front();
        ok       = 1;
        label    = $sformatf("%0d inst %h", t, golden[t*COLS+1]);
        assert (cycle == ack_edge + 2) else begin   // Two edges after ack
          $display("Test %0d result came %0d edges after ack, not 2", t, cycle - ack_edge);
          errors++;
          ok = 0;
        end
        check_field(label, "result_wen",   result_wen,   golden[t*COLS+2], ok);
        check_field(label, "result_rd",    result_rd,    golden[t*COLS+3], ok);
        check_field(label, "result_data",  result_data,  golden[t*COLS+4], ok);
        check_field(label, "result_taken", result_taken, golden[t*COLS+5], ok);
        report_test(label, ok);
      end
    end
  endtask

  task automatic tick();
    @(posedge clk);
    #DRIVE_DLY;      // Drive and sample point
    cycle++;
    check_result();
  endtask

  // ----------------------------------------
  // Bus master, one golden line
  // ----------------------------------------
  task automatic run_test(input int t);
    logic [1:0] gap;
    int         n;
    bit         ok;
    lfsr   = lfsr_next(lfsr);
    gap[1] = lfsr[0];
    lfsr   = lfsr_next(lfsr);
    gap[0] = lfsr[0];
    if (t % 2 == 1) gap = 2'd0;   // Odd lines back to back, writeback bypass
    repeat (gap) tick();
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = golden[t*COLS][0];
    wb_dat_i = golden[t*COLS+1];
    tick();
    n = 1;
    while (wb_ack !== 1'b1 && n < WAIT_LIMIT) begin
      tick();
      n++;
    end
    wb_cyc = 1'b0;                // Strobe low for the ack cycle
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    ok     = 1;
    if (wb_ack !== 1'b1) begin
      $display("Timeout: no wb_ack for test %0d within %0d cycles", t, WAIT_LIMIT);
      errors++;
      aborted = 1;
      report_test($sformatf("%0d", t), 0);
    end else if (golden[t*COLS][0]) begin
      issue_q.push_back(t);
      ack_q.push_back(cycle);
      tick();
      assert (wb_ack === 1'b0) else begin
        $display("wb_ack stayed high for more than one cycle in test %0d", t);
        errors++;
      end
    end else begin
      // Read cycle, acked but nothing issued
      tick();
      tick();
      assert (result_valid !== 1'b1) else begin
        $display("Read cycle of test %0d produced a result", t);
        errors++;
        ok = 0;
      end
      report_test($sformatf("%0d read cycle", t), ok);
    end
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin : main
    int t;
    bit ok;
    clk          = 1'b0;
    reset        = 1'b1;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_dat_i     = '0;
    cycle        = 0;
    tests_run    = 0;
    tests_failed = 0;
    errors       = 0;
    aborted      = 0;
    lfsr         = 32'h5a64_38d1;

    $readmemh("tb/alu_golden.txt", golden);
    n_tests = 0;
    while (n_tests < MAX_TESTS && !$isunknown(golden[n_tests*COLS])) n_tests++;
    assert (n_tests > 0) else begin
      $display("No test lines could be read from tb/alu_golden.txt");
      errors++;
    end

    tick();                      // Reset over two edges
    tick();
    reset = 1'b0;

    // Quiet bus after reset
    ok = 1;
    repeat (4) begin
      tick();
      check_field("idle", "wb_ack",       wb_ack,       32'h0, ok);
      check_field("idle", "result_valid", result_valid, 32'h0, ok);
      check_field("idle", "result_taken", result_taken, 32'h0, ok);
    end
    report_test("idle after reset", ok);

    t = 0;
    while (t < n_tests && !aborted) begin
      run_test(t);
      t++;
    end

    // Let the last instructions reach writeback
    t = 0;
    while (issue_q.size() != 0 && t < WAIT_LIMIT && !aborted) begin
      tick();
      t++;
    end
    if (issue_q.size() != 0 && !aborted) begin
      $display("Timeout: %0d issued instructions never produced a result", issue_q.size());
      errors++;
      aborted = 1;
    end
    repeat (4) tick();           // Catch stray results

    $display("Tests: %0d run, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0 && !aborted)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== design/rv_alu_pipe_top.sv ====
// RISC-V integer execute pipeline, top level
// Wishbone instruction slave, decode, register file, execute, writeback
`timescale 1ns/1ns

module rv_alu_pipe_top (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [31:0]           wb_dat_i,   // Instruction word
  output logic                  wb_ack,
  output logic                  result_valid,
  output logic                  result_wen,
  output rv_isa_pkg::reg_addr_t result_rd,
  output rv_isa_pkg::word_t     result_data,
  output logic                  result_taken
);

  logic                  inst_valid;
  logic [31:0]           inst;
  rv_isa_pkg::reg_addr_t rs1_addr;
  rv_isa_pkg::reg_addr_t rs2_addr;
  rv_isa_pkg::word_t     rs1_data;
  rv_isa_pkg::word_t     rs2_data;
  logic                  rf_wen;
  rv_isa_pkg::reg_addr_t rf_waddr;
  rv_isa_pkg::word_t     rf_wdata;

  dx_if dx ();
  xw_if xw ();

  // ----------------------------------------
  // Input side
  // ----------------------------------------
  inst_wb_slave u_slave (
    .clk        (clk),
    .reset      (reset),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_dat_i   (wb_dat_i),
    .wb_ack     (wb_ack),
    .inst_valid (inst_valid),
    .inst       (inst)
  );

  // ----------------------------------------
  // Decode, register file, execute
  // ----------------------------------------
  decode_stage u_decode (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .xw         (xw.bypass),
    .dx         (dx.src)
  );

  regfile u_regfile (
    .clk      (clk),
    .reset    (reset),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wen      (rf_wen),
    .waddr    (rf_waddr),
    .wdata    (rf_wdata)
  );

  execute_stage u_execute (
    .clk   (clk),
    .reset (reset),
    .dx    (dx.dst),
    .xw    (xw.src)
  );

  // ----------------------------------------
  // Output side
  // ----------------------------------------
  writeback_stage u_writeback (
    .xw           (xw.dst),
    .rf_wen       (rf_wen),
    .rf_waddr     (rf_waddr),
    .rf_wdata     (rf_wdata),
    .result_valid (result_valid),
    .result_wen   (result_wen),
    .result_taken (result_taken),
    .result_rd    (result_rd),
    .result_data  (result_data)
  );

endmodule

// ==== design/writeback_stage.sv ====
// Writeback stage
// Register file write and result report from the xw register
`timescale 1ns/1ns

module writeback_stage (
  xw_if.dst                     xw,
  output logic                  rf_wen,
  output rv_isa_pkg::reg_addr_t rf_waddr,
  output rv_isa_pkg::word_t     rf_wdata,
  output logic                  result_valid,
  output logic                  result_wen,
  output logic                  result_taken,
  output rv_isa_pkg::reg_addr_t result_rd,
  output rv_isa_pkg::word_t     result_data
);

  logic do_write;   // Valid write to a real register

  assign do_write = xw.valid && xw.wen && (xw.rd != '0);

  // Register file side
  assign rf_wen   = do_write;
  assign rf_waddr = xw.rd;
  assign rf_wdata = xw.data;

  // Result report, one cycle per instruction
  assign result_valid = xw.valid;
  assign result_wen   = do_write;   // Low for x0 and branches
  assign result_rd    = xw.rd;
  assign result_data  = xw.data;
  assign result_taken = xw.valid && xw.taken;

endmodule

// ==== design/execute_stage.sv ====
// Execute stage: ALU and branch comparator
// Results registered into the xw pipeline register
`timescale 1ns/1ns

module execute_stage (
  input  logic clk,
  input  logic reset,
  dx_if.dst    dx,
  xw_if.src    xw
);

  rv_isa_pkg::word_t alu_out;
  rv_isa_pkg::word_t result;
  logic [4:0]        shamt;
  logic              eq;
  logic              lt;    // Signed
  logic              ltu;
  logic              taken;
  logic              is_br;

  assign shamt = dx.op1[4:0];
  assign eq    = (dx.op0 == dx.op1);
  assign lt    = ($signed(dx.op0) < $signed(dx.op1));  // Shared with slt
  assign ltu   = (dx.op0 < dx.op1);
  assign is_br = (dx.br_fn != rv_pipe_pkg::BR_NONE);

  // ----------------------------------------
  // ALU
  // ----------------------------------------
  always_comb begin
    case (dx.alu_fn)
      rv_pipe_pkg::ALU_ADD:  alu_out = dx.op0 + dx.op1;
      rv_pipe_pkg::ALU_SUB:  alu_out = dx.op0 - dx.op1;
      rv_pipe_pkg::ALU_SLL:  alu_out = dx.op0 << shamt;
      rv_pipe_pkg::ALU_SLT:  alu_out = {31'b0, lt};
      rv_pipe_pkg::ALU_SLTU: alu_out = {31'b0, ltu};
      rv_pipe_pkg::ALU_XOR:  alu_out = dx.op0 ^ dx.op1;
      rv_pipe_pkg::ALU_SRL:  alu_out = dx.op0 >> shamt;
      rv_pipe_pkg::ALU_SRA:  alu_out = $signed(dx.op0) >>> shamt;
      rv_pipe_pkg::ALU_OR:   alu_out = dx.op0 | dx.op1;
      rv_pipe_pkg::ALU_AND:  alu_out = dx.op0 & dx.op1;
      default:               alu_out = '0;
    endcase
  end

  // Branch outcome
  always_comb begin
    case (dx.br_fn)
      rv_pipe_pkg::BR_EQ:  taken = eq;
      rv_pipe_pkg::BR_NE:  taken = !eq;
      rv_pipe_pkg::BR_LT:  taken = lt;
      rv_pipe_pkg::BR_LTU: taken = ltu;
      rv_pipe_pkg::BR_GE:  taken = !lt;
      rv_pipe_pkg::BR_GEU: taken = !ltu;
      default:             taken = 1'b0;   // Not a branch
    endcase
  end

  assign result = is_br ? '0 : alu_out;   // Branches carry no data

  // ----------------------------------------
  // W <- X
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      xw.valid <= 1'b0;
      xw.wen   <= 1'b0;
      xw.taken <= 1'b0;
    end else begin
      xw.valid <= dx.valid;
      xw.wen   <= dx.wen && !is_br;
      xw.taken <= dx.valid && taken;
    end
  end

  always_ff @(posedge clk) begin
    xw.rd   <= dx.rd;
    xw.data <= result;
  end

endmodule

// ==== design/regfile.sv ====
// Integer register file, 32 x 32
// Two combinational reads, one synchronous write, x0 reads zero
`timescale 1ns/1ns

module regfile (
  input  logic                  clk,
  input  logic                  reset,
  input  rv_isa_pkg::reg_addr_t rs1_addr,
  input  rv_isa_pkg::reg_addr_t rs2_addr,
  output rv_isa_pkg::word_t     rs1_data,
  output rv_isa_pkg::word_t     rs2_data,
  input  logic                  wen,
  input  rv_isa_pkg::reg_addr_t waddr,
  input  rv_isa_pkg::word_t     wdata
);

  rv_isa_pkg::word_t regs [32];

  // x0 forced on the read side
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;  // All registers read zero
    end else if (wen) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

// ==== design/decode_stage.sv ====
// Decode stage: fields, immediates, register read with writeback bypass
// Operand select and control decode into the dx register
`timescale 1ns/1ns

module decode_stage (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  inst_valid,
  input  rv_isa_pkg::word_t     inst,
  output rv_isa_pkg::reg_addr_t rs1_addr,
  output rv_isa_pkg::reg_addr_t rs2_addr,
  input  rv_isa_pkg::word_t     rs1_data,
  input  rv_isa_pkg::word_t     rs2_data,
  xw_if.bypass                  xw,
  dx_if.src                     dx
);

  rv_isa_pkg::opcode_t   opcode;
  rv_isa_pkg::reg_addr_t rd;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  rv_isa_pkg::word_t     imm_i;
  rv_isa_pkg::word_t     imm_u;
  rv_isa_pkg::word_t     imm_sb;
  rv_pipe_pkg::alu_fn_e  alu_fn;
  rv_pipe_pkg::br_fn_e   br_fn;
  rv_pipe_pkg::op0_sel_e op0_sel;
  rv_pipe_pkg::op1_sel_e op1_sel;
  logic                  wen;
  logic                  legal;     // Low for unsupported encodings
  logic                  byp1;
  logic                  byp2;
  rv_isa_pkg::word_t     rs1_val;
  rv_isa_pkg::word_t     rs2_val;
  rv_isa_pkg::word_t     op0_val;
  rv_isa_pkg::word_t     op1_val;

  // funct3 to ALU function, alt picks sub / sra
  function automatic rv_pipe_pkg::alu_fn_e alu_of(input logic [2:0] f3, input logic alt);
    case (f3)
      rv_isa_pkg::F3_ADD_SUB: alu_of = alt ? rv_pipe_pkg::ALU_SUB : rv_pipe_pkg::ALU_ADD;
      rv_isa_pkg::F3_SLL:     alu_of = rv_pipe_pkg::ALU_SLL;
      rv_isa_pkg::F3_SLT:     alu_of = rv_pipe_pkg::ALU_SLT;
      rv_isa_pkg::F3_SLTU:    alu_of = rv_pipe_pkg::ALU_SLTU;
      rv_isa_pkg::F3_XOR:     alu_of = rv_pipe_pkg::ALU_XOR;
      rv_isa_pkg::F3_SRL_SRA: alu_of = alt ? rv_pipe_pkg::ALU_SRA : rv_pipe_pkg::ALU_SRL;
      rv_isa_pkg::F3_OR:      alu_of = rv_pipe_pkg::ALU_OR;
      default:                alu_of = rv_pipe_pkg::ALU_AND;
    endcase
  endfunction

  // ----------------------------------------
  // Fields and immediates
  // ----------------------------------------
  assign opcode   = inst[6:0];
  assign rd       = inst[11:7];
  assign funct3   = inst[14:12];
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];
  assign funct7   = inst[31:25];
  assign imm_i    = {{20{inst[31]}}, inst[31:20]};
  assign imm_u    = {inst[31:12], 12'b0};
  assign imm_sb   = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

  // ----------------------------------------
  // Control decode
  // ----------------------------------------
  always_comb begin
    alu_fn  = rv_pipe_pkg::ALU_ADD;   // Default is add of zeros
    br_fn   = rv_pipe_pkg::BR_NONE;
    op0_sel = rv_pipe_pkg::OP0_ZERO;
    op1_sel = rv_pipe_pkg::OP1_RDAT;
    wen     = 1'b0;
    legal   = 1'b1;
    case (opcode)
      rv_isa_pkg::OPC_OP: begin
        alu_fn  = alu_of(funct3, funct7[rv_isa_pkg::F7_ALT_BIT]);
        op0_sel = rv_pipe_pkg::OP0_RDAT;
        wen     = 1'b1;
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        // No subi, alt bit only means srai
        alu_fn  = alu_of(funct3, (funct3 == rv_isa_pkg::F3_SRL_SRA) &&
                                 funct7[rv_isa_pkg::F7_ALT_BIT]);
        op0_sel = rv_pipe_pkg::OP0_RDAT;
        op1_sel = rv_pipe_pkg::OP1_IMM_I;   // Shamt in low 5 bits
        wen     = 1'b1;
      end
      rv_isa_pkg::OPC_LUI: begin
        op1_sel = rv_pipe_pkg::OP1_IMM_U;   // 0 + imm_u
        wen     = 1'b1;
      end
      rv_isa_pkg::OPC_BRANCH: begin
        op0_sel = rv_pipe_pkg::OP0_RDAT;    // Compare rs1 with rs2
        case (funct3)
          rv_isa_pkg::F3_BEQ:  br_fn = rv_pipe_pkg::BR_EQ;
          rv_isa_pkg::F3_BNE:  br_fn = rv_pipe_pkg::BR_NE;
          rv_isa_pkg::F3_BLT:  br_fn = rv_pipe_pkg::BR_LT;
          rv_isa_pkg::F3_BGE:  br_fn = rv_pipe_pkg::BR_GE;
          rv_isa_pkg::F3_BLTU: br_fn = rv_pipe_pkg::BR_LTU;
          rv_isa_pkg::F3_BGEU: br_fn = rv_pipe_pkg::BR_GEU;
          default:             legal = 1'b0;
        endcase
      end
      default: legal = 1'b0;
    endcase
  end

  // Writeback bypass, regfile not written until end of this cycle
  assign byp1    = xw.valid && xw.wen && (xw.rd != '0) && (xw.rd == rs1_addr);
  assign byp2    = xw.valid && xw.wen && (xw.rd != '0) && (xw.rd == rs2_addr);
  assign rs1_val = byp1 ? xw.data : rs1_data;
  assign rs2_val = byp2 ? xw.data : rs2_data;

  assign op0_val = (op0_sel == rv_pipe_pkg::OP0_RDAT) && legal ? rs1_val : '0;

  always_comb begin
    case (op1_sel)
      rv_pipe_pkg::OP1_IMM_I:  op1_val = imm_i;
      rv_pipe_pkg::OP1_IMM_U:  op1_val = imm_u;
      rv_pipe_pkg::OP1_IMM_SB: op1_val = imm_sb;
      default:                 op1_val = rs2_val;
    endcase
  end

  // ----------------------------------------
  // X <- D
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      dx.valid <= 1'b0;
      dx.wen   <= 1'b0;
      dx.br_fn <= rv_pipe_pkg::BR_NONE;
    end else begin
      dx.valid <= inst_valid;
      dx.wen   <= wen && legal;
      dx.br_fn <= br_fn;
    end
  end

  always_ff @(posedge clk) begin
    dx.rd     <= rd;
    dx.alu_fn <= alu_fn;
    dx.op0    <= op0_val;
    dx.op1    <= legal ? op1_val : '0;  // Unsupported gives 0 + 0
  end

endmodule

// ==== design/inst_wb_slave.sv ====
// Wishbone classic slave for instruction issue
// One word per bus cycle, ack held for a single clock
`timescale 1ns/1ns

module inst_wb_slave (
  input  logic        clk,
  input  logic        reset,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [31:0] wb_dat_i,
  output logic        wb_ack,
  output logic        inst_valid,
  output logic [31:0] inst
);

  rv_pipe_pkg::slave_state_e state;
  logic                      take;  // New strobe seen in idle

  assign take   = (state == rv_pipe_pkg::ST_IDLE) && wb_cyc && wb_stb;
  assign wb_ack = (state == rv_pipe_pkg::ST_ACK);   // One cycle per request

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= rv_pipe_pkg::ST_IDLE;
      inst_valid <= 1'b0;
    end else begin
      inst_valid <= take && wb_we;  // Reads ack without issue
      if (take)
        state <= rv_pipe_pkg::ST_ACK;
      else
        state <= rv_pipe_pkg::ST_IDLE;  // Ack cycle always returns
    end
  end

  // Instruction word, D register
  always_ff @(posedge clk) begin
    if (take) inst <= wb_dat_i;
  end

endmodule

// ==== design/xw_if.sv ====
// Execute to writeback pipeline register
// Also read by decode for the writeback bypass
`timescale 1ns/1ns

interface xw_if;

  logic                  valid;
  logic                  wen;
  rv_isa_pkg::reg_addr_t rd;
  rv_isa_pkg::word_t     data;    // ALU result, zero for branches
  logic                  taken;   // Branch outcome

  modport src    (output valid, wen, rd, data, taken);
  modport dst    (input  valid, wen, rd, data, taken);
  modport bypass (input  valid, wen, rd, data);  // No taken needed here

endinterface

// ==== design/dx_if.sv ====
// Decode to execute pipeline register
// Written by decode at the end of the decode cycle
`timescale 1ns/1ns

interface dx_if;

  logic                  valid;   // Instruction in execute
  rv_isa_pkg::reg_addr_t rd;
  logic                  wen;     // Writes rd
  rv_pipe_pkg::alu_fn_e  alu_fn;
  rv_pipe_pkg::br_fn_e   br_fn;
  rv_isa_pkg::word_t     op0;     // Selected operands
  rv_isa_pkg::word_t     op1;

  modport src (output valid, rd, wen, alu_fn, br_fn, op0, op1);
  modport dst (input  valid, rd, wen, alu_fn, br_fn, op0, op1);

endinterface

// ==== design/rv_pipe_pkg.sv ====
// Pipeline control encodings
// ALU and branch functions, operand selects, bus slave states
package rv_pipe_pkg;

  // ALU function, decided in decode, applied in execute
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_fn_e;

  // Branch compare kind, BR_NONE for plain ALU ops
  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_LTU,
    BR_GE,
    BR_GEU
  } br_fn_e;

  typedef enum logic [1:0] {OP1_RDAT, OP1_IMM_I, OP1_IMM_U, OP1_IMM_SB} op1_sel_e;
  typedef enum logic       {OP0_RDAT, OP0_ZERO} op0_sel_e;  // Zero for LUI

  // Wishbone slave FSM
  typedef enum logic {ST_IDLE, ST_ACK} slave_state_e;

endpackage

// ==== design/rv_isa_pkg.sv ====
// RISC-V integer ISA definitions
// Word and register types, kept major opcodes and funct fields
package rv_isa_pkg;

  typedef logic [31:0] word_t;      // Data or instruction word
  typedef logic [4:0]  reg_addr_t;  // x0..x31
  typedef logic [6:0]  opcode_t;    // inst[6:0]

  // ----------------------------------------
  // Major opcodes
  // ----------------------------------------
  localparam opcode_t OPC_OP     = 7'b0110011;  // R-type ALU
  localparam opcode_t OPC_OP_IMM = 7'b0010011;  // I-type ALU
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;  // beq..bgeu

  // ----------------------------------------
  // funct3 values
  // ----------------------------------------
  // ALU ops, shared by OP and OP_IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // Branch kinds
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // funct7 bit that turns add into sub, srl into sra (inst[30])
  localparam int F7_ALT_BIT = 5;

endpackage
